// ==== common/lc3b_types.sv ====
package lc3b_types;

localparam int l2_ways = 4;
localparam int l2_sets = 16;
localparam int l2_line_bytes = 16;

typedef logic [15:0] lc3b_word;
typedef logic [127:0] lc3b_data;

// address parts.
typedef logic [7:0] lc3b_l2_tag;
typedef logic [3:0] lc3b_l2_index;
typedef logic [2:0] lc3b_offset;

typedef logic [1:0] lc3b_l2_way;
typedef logic [2:0] lc3b_l2_lru;	// tree pseudo-lru bits.

typedef struct packed
{
	logic [l2_ways-1:0] valid_write;
	logic [l2_ways-1:0] dirty_write;
	logic [l2_ways-1:0] tag_write;
	logic [l2_ways-1:0] data_write;
	logic lru_write;
	logic valid_in;
	logic dirty_in;
	lc3b_l2_lru lru_in;
	logic data_sig;			// 1 selects memory line.
	logic pmem_addr_sig;	// 1 selects writeback address.
} l2_ctrl_t;

typedef struct packed
{
	logic hit;
	lc3b_l2_way hit_way;
	lc3b_l2_lru lru_out;
	logic dirty_out;		// dirty bit of the victim.
	lc3b_l2_way victim_way;
} l2_status_t;

endpackage

// ==== design/l2_array.sv ====
`timescale 1ns/1ps

module l2_array import lc3b_types::*;
#(
	parameter type payload_t = logic
)
(
	input logic clk,
	input logic reset,
	input logic write,
	input lc3b_l2_index index,
	input payload_t datain,
	output payload_t dataout
);

payload_t data [l2_sets];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int i = 0; i < l2_sets; i++)
			data[i] <= '0;
	end
	else if (write)
		data[index] <= datain;
end

assign dataout = data[index];	// read is combinational.

// the index comes from the requester, so it must be clean when we write.
index_known_on_write: assert property (@(posedge clk) disable iff (reset)
	write |-> !$isunknown(index))
	else $error("l2_array write with unknown index");

endmodule : l2_array

// ==== l2_cache/l2_cache_datapath.sv ====
`timescale 1ns/1ps

module l2_cache_datapath import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input lc3b_word mem_address,
	input lc3b_data mem_wdata,
	input lc3b_word mem_byte_enable,
	input lc3b_data pmem_rdata,
	input l2_ctrl_t ctrl,
	output l2_status_t status,
	output lc3b_data mem_rdata,
	output lc3b_data pmem_wdata,
	output lc3b_word pmem_address
);

lc3b_l2_tag tag;
lc3b_l2_index index;

logic [l2_ways-1:0] valid_out;
logic [l2_ways-1:0] dirty_out;
logic [l2_ways-1:0] match;
lc3b_l2_tag tag_out [l2_ways];
lc3b_data line_out [l2_ways];
lc3b_l2_lru lru_out;

lc3b_l2_way hit_way;
lc3b_l2_way victim_way;
lc3b_data hit_line;
lc3b_data merged;
lc3b_data data_in;
lc3b_word request_addr;
lc3b_word writeback_addr;

assign tag = mem_address[15:8];
assign index = mem_address[7:4];

genvar w;
generate
	for (w = 0; w < l2_ways; w++)
	begin : way
		l2_array #(.payload_t(logic)) valid_array
		(
			.clk(clk),
			.reset(reset),
			.write(ctrl.valid_write[w]),
			.index(index),
			.datain(ctrl.valid_in),
			.dataout(valid_out[w])
		);

		l2_array #(.payload_t(logic)) dirty_array
		(
			.clk(clk),
			.reset(reset),
			.write(ctrl.dirty_write[w]),
			.index(index),
			.datain(ctrl.dirty_in),
			.dataout(dirty_out[w])
		);

		l2_array #(.payload_t(lc3b_l2_tag)) tag_array
		(
			.clk(clk),
			.reset(reset),
			.write(ctrl.tag_write[w]),
			.index(index),
			.datain(tag),
			.dataout(tag_out[w])
		);

		l2_array #(.payload_t(lc3b_data)) data_array
		(
			.clk(clk),
			.reset(reset),
			.write(ctrl.data_write[w]),
			.index(index),
			.datain(data_in),
			.dataout(line_out[w])
		);

		assign match[w] = valid_out[w] && (tag_out[w] == tag);
	end
endgenerate

l2_array #(.payload_t(lc3b_l2_lru)) lru_array
(
	.clk(clk),
	.reset(reset),
	.write(ctrl.lru_write),
	.index(index),
	.datain(ctrl.lru_in),
	.dataout(lru_out)
);

// encode the matching way; lowest wins if the tags ever alias.
always_comb
begin
	hit_way = '0;
	for (int i = l2_ways - 1; i >= 0; i--)
		if (match[i])
			hit_way = lc3b_l2_way'(i);
end

always_comb
begin
	if (lru_out[0])
		victim_way = lru_out[1] ? 2'd0 : 2'd1;
	else
		victim_way = lru_out[2] ? 2'd2 : 2'd3;
end

assign hit_line = line_out[hit_way];

// byte merge of the cpu write over the hit line.
always_comb
begin
	merged = hit_line;
	for (int i = 0; i < l2_line_bytes; i++)
		if (mem_byte_enable[i])
			merged[i*8 +: 8] = mem_wdata[i*8 +: 8];
end

assign data_in = ctrl.data_sig ? pmem_rdata : merged;

assign request_addr = {tag, index, lc3b_offset'(0), 1'b0};
assign writeback_addr = {tag_out[victim_way], index, lc3b_offset'(0), 1'b0};	// line aligned.
assign pmem_address = ctrl.pmem_addr_sig ? writeback_addr : request_addr;
assign pmem_wdata = line_out[victim_way];

assign mem_rdata = hit_line;

assign status.hit = |match;
assign status.hit_way = hit_way;
assign status.lru_out = lru_out;
assign status.dirty_out = dirty_out[victim_way];
assign status.victim_way = victim_way;

// allocate only ever fills a way whose tag missed, so no set holds a tag twice.
single_way_match: assert property (@(posedge clk) disable iff (reset)
	$onehot0(match))
	else $error("more than one way matches tag %h in set %0d", tag, index);

endmodule : l2_cache_datapath

// ==== l2_cache/l2_cache_control.sv ====
`timescale 1ns/1ps

module l2_cache_control import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic mem_read,
	input logic mem_write,
	input l2_status_t status,
	input logic pmem_resp,
	output l2_ctrl_t ctrl,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write
);

typedef enum logic [1:0]
{
	s_check,
	s_writeback,
	s_allocate
} state_t;

state_t state;
state_t next_state;
lc3b_l2_lru lru_next;

// pseudo-lru update, pointing the tree away from the way just used.
always_comb
begin
	lru_next = status.lru_out;
	case (status.hit_way)
		2'd0: lru_next = {status.lru_out[2], 2'b00};
		2'd1: lru_next = {status.lru_out[2], 2'b10};
		2'd2: lru_next = {1'b0, status.lru_out[1], 1'b1};
		2'd3: lru_next = {1'b1, status.lru_out[1], 1'b1};
		default: lru_next = status.lru_out;
	endcase
end

always_comb
begin
	ctrl = '0;
	ctrl.lru_in = lru_next;
	mem_resp = 1'b0;
	pmem_read = 1'b0;
	pmem_write = 1'b0;
	next_state = state;

	case (state)
		s_check:
		begin
			if ((mem_read || mem_write) && status.hit)
			begin
				mem_resp = 1'b1;
				ctrl.lru_write = 1'b1;
				if (mem_write)
				begin
					ctrl.data_write[status.hit_way] = 1'b1;
					ctrl.dirty_write[status.hit_way] = 1'b1;
					ctrl.dirty_in = 1'b1;
				end
			end
			else if (mem_read || mem_write)
				next_state = status.dirty_out ? s_writeback : s_allocate;
		end

		s_writeback:
		begin
			pmem_write = 1'b1;
			ctrl.pmem_addr_sig = 1'b1;	// victim tag, same index.
			if (pmem_resp)
				next_state = s_allocate;
		end

		s_allocate:
		begin
			pmem_read = 1'b1;
			ctrl.data_sig = 1'b1;
			if (pmem_resp)
			begin
				ctrl.data_write[status.victim_way] = 1'b1;
				ctrl.tag_write[status.victim_way] = 1'b1;
				ctrl.valid_write[status.victim_way] = 1'b1;
				ctrl.dirty_write[status.victim_way] = 1'b1;
				ctrl.valid_in = 1'b1;
				next_state = s_check;	// the retry hits.
			end
		end

		default: next_state = s_check;
	endcase
end

always_ff @(posedge clk)
begin
	if (reset)
		state <= s_check;
	else
		state <= next_state;
end

cpu_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
	!(mem_read && mem_write))
	else $error("mem_read and mem_write high together");

pmem_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
	!(pmem_read && pmem_write))
	else $error("pmem_read and pmem_write high together");

endmodule : l2_cache_control

// ==== l2_cache/l2_cache.sv ====
`timescale 1ns/1ps

module l2_cache import lc3b_types::*;
(
	input logic clk,
	input logic reset,

	input lc3b_word mem_address,
	input logic mem_read,
	input logic mem_write,
	input lc3b_word mem_byte_enable,
	input lc3b_data mem_wdata,
	output lc3b_data mem_rdata,
	output logic mem_resp,

	output lc3b_word pmem_address,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_data pmem_wdata,
	input lc3b_data pmem_rdata,
	input logic pmem_resp
);

l2_ctrl_t ctrl;
l2_status_t status;

l2_cache_control control
(
	.clk(clk),
	.reset(reset),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.status(status),
	.pmem_resp(pmem_resp),
	.ctrl(ctrl),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write)
);

l2_cache_datapath datapath
(
	.clk(clk),
	.reset(reset),
	.mem_address(mem_address),
	.mem_wdata(mem_wdata),
	.mem_byte_enable(mem_byte_enable),
	.pmem_rdata(pmem_rdata),
	.ctrl(ctrl),
	.status(status),
	.mem_rdata(mem_rdata),
	.pmem_wdata(pmem_wdata),
	.pmem_address(pmem_address)
);

endmodule : l2_cache

// ==== verification/l2_mem_model.sv ====
`timescale 1ns/1ps

module l2_mem_model import lc3b_types::*;
#(
	parameter int delay = 4,
	parameter int seed_init = 32'h712e_8c4a
)
(
	input logic clk,
	input logic reset,
	input lc3b_word pmem_address,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_data pmem_wdata,
	output lc3b_data pmem_rdata,
	output logic pmem_resp
);

lc3b_data lines [4096];
int count;
int seed;

initial
begin
	seed = seed_init;
	for (int i = 0; i < 4096; i++)
		lines[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
end

// a strobe held for delay cycles gets a one cycle response.
always @(posedge clk)
begin
	if (reset)
	begin
		pmem_resp <= 1'b0;
		pmem_rdata <= '0;
		count <= 0;
	end
	else
	begin
		pmem_resp <= 1'b0;
		if ((pmem_read || pmem_write) && !pmem_resp)
		begin
			if (count == delay - 1)
			begin
				count <= 0;
				pmem_resp <= 1'b1;
				pmem_rdata <= lines[pmem_address[15:4]];
				if (pmem_write)
					lines[pmem_address[15:4]] <= pmem_wdata;
			end
			else
				count <= count + 1;
		end
	end
end

endmodule : l2_mem_model

// ==== verification/l2_cache_tb.sv ====
`timescale 1ns/1ps

module l2_cache_tb import lc3b_types::*;
();

logic clk;
logic reset;
lc3b_word mem_address;
logic mem_read;
logic mem_write;
lc3b_word mem_byte_enable;
lc3b_data mem_wdata;
lc3b_data mem_rdata;
logic mem_resp;
lc3b_word pmem_address;
logic pmem_read;
logic pmem_write;
lc3b_data pmem_wdata;
lc3b_data pmem_rdata;
logic pmem_resp;

// reference model state.
lc3b_data cpu_view [4096];
lc3b_l2_tag mtag [l2_sets][l2_ways];
bit mvalid [l2_sets][l2_ways];
bit mdirty [l2_sets][l2_ways];
lc3b_l2_lru mlru [l2_sets];
bit exp_kind [$];	// 1 is a writeback.
lc3b_word exp_addr [$];
lc3b_data exp_data [$];
string test_name;
int seed;

l2_cache UUT
(
	.clk(clk), .reset(reset),
	.mem_address(mem_address), .mem_read(mem_read), .mem_write(mem_write),
	.mem_byte_enable(mem_byte_enable), .mem_wdata(mem_wdata),
	.mem_rdata(mem_rdata), .mem_resp(mem_resp),
	.pmem_address(pmem_address), .pmem_read(pmem_read), .pmem_write(pmem_write),
	.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
);

l2_mem_model memory
(
	.clk(clk), .reset(reset),
	.pmem_address(pmem_address), .pmem_read(pmem_read), .pmem_write(pmem_write),
	.pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
);

always #50 clk = ~clk;

task automatic stop_on_error(string msg);
	$display("%s", msg);
	$display("*** TEST FAILED ***");
	$fatal(1, "simulation stopped");
endtask

task automatic compare_line(string name, lc3b_data expected, lc3b_data actual);
	if (expected !== actual)
		stop_on_error($sformatf("** Error %s: expected %h actual %h", name, expected, actual));
endtask

task automatic compare_addr(string name, lc3b_word expected, lc3b_word actual);
	if (expected !== actual)
		stop_on_error($sformatf("** Error %s: expected %h actual %h", name, expected, actual));
endtask

function automatic lc3b_l2_way victim_of(lc3b_l2_lru t);
	if (t[0])
		return t[1] ? 2'd0 : 2'd1;
	return t[2] ? 2'd2 : 2'd3;
endfunction

// bit0 records the used pair, bit1 or bit2 the used way within it.
function automatic lc3b_l2_lru touch(lc3b_l2_lru t, lc3b_l2_way w);
	lc3b_l2_lru result;
	result = t;
	result[0] = w[1];
	if (w[1])
		result[2] = w[0];
	else
		result[1] = w[0];
	return result;
endfunction

function automatic lc3b_data merge_line(lc3b_data old, lc3b_data wdata, lc3b_word be);
	lc3b_data result;
	result = old;
	for (int i = 0; i < l2_line_bytes; i++)
		if (be[i])
			result[i*8 +: 8] = wdata[i*8 +: 8];
	return result;
endfunction

function automatic lc3b_word writeback_addr(lc3b_l2_tag t, lc3b_l2_index idx);
	return {t, idx, 4'h0};
endfunction

// updates the model for one access and queues the pmem traffic it predicts.
task automatic access(string name, lc3b_word addr, logic write, lc3b_word be, lc3b_data wdata);
	lc3b_l2_index idx;
	lc3b_l2_tag t;
	lc3b_l2_way w;
	lc3b_data expected;
	bit hit;
	int n;
	test_name = name;
	idx = addr[7:4];
	t = addr[15:8];
	hit = 0;
	w = 2'd0;
	for (int i = 0; i < l2_ways; i++)
		if (mvalid[idx][i] && mtag[idx][i] == t)
		begin
			hit = 1;
			w = lc3b_l2_way'(i);
		end
	if (!hit)
	begin
		w = victim_of(mlru[idx]);
		if (mdirty[idx][w])
		begin
			exp_kind.push_back(1'b1);
			exp_addr.push_back(writeback_addr(mtag[idx][w], idx));
			exp_data.push_back(cpu_view[{mtag[idx][w], idx}]);
		end
		exp_kind.push_back(1'b0);
		exp_addr.push_back({t, idx, 4'h0});
		exp_data.push_back('0);
		mtag[idx][w] = t;
		mvalid[idx][w] = 1;
		mdirty[idx][w] = 0;
	end
	mlru[idx] = touch(mlru[idx], w);
	expected = cpu_view[addr[15:4]];
	if (write)
	begin
		mdirty[idx][w] = 1;
		cpu_view[addr[15:4]] = merge_line(expected, wdata, be);
	end

	@(posedge clk);
	mem_address <= addr;
	mem_read <= !write;
	mem_write <= write;
	mem_byte_enable <= be;
	mem_wdata <= wdata;
	n = 0;
	@(negedge clk);
	while (!mem_resp)
	begin
		if (n == 200)
			stop_on_error($sformatf("%s: no mem_resp within 200 cycles", name));
		n++;
		@(negedge clk);
	end
	if (!write)
		compare_line(name, expected, mem_rdata);
	if (exp_kind.size() != 0)
		stop_on_error($sformatf("%s: predicted memory transfer never happened", name));
	@(posedge clk);
	mem_read <= 1'b0;
	mem_write <= 1'b0;
	@(posedge clk);
endtask

// compares every pmem transfer against the predicted queue.
always @(negedge clk)
begin
	if (!reset)
	begin
		if ((pmem_read || pmem_write) && exp_kind.size() == 0)
			stop_on_error($sformatf("%s: memory strobe raised where none was expected",
				test_name));
		else if (pmem_resp)
		begin
			if (pmem_write !== exp_kind[0])
				stop_on_error($sformatf("%s: memory transfer of the wrong kind or order",
					test_name));
			compare_addr($sformatf("%s pmem address", test_name), exp_addr[0], pmem_address);
			if (pmem_write)
				compare_line($sformatf("%s writeback data", test_name), exp_data[0],
					pmem_wdata);
			void'(exp_kind.pop_front());
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
		end
	end
end

initial
begin
	lc3b_word addr;
	logic [31:0] r;
	lc3b_l2_index sets [3];
	clk = 1'b0;
	reset = 1'b1;
	mem_address = '0;
	mem_read = 1'b0;
	mem_write = 1'b0;
	mem_byte_enable = '0;
	mem_wdata = '0;
	test_name = "after reset";
	sets = '{4'd2, 4'd9, 4'd14};
	seed = 32'h712e_8c4a;
	for (int i = 0; i < 4096; i++)
		cpu_view[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
	for (int s = 0; s < l2_sets; s++)
	begin
		mlru[s] = '0;
		for (int w = 0; w < l2_ways; w++)
		begin
			mtag[s][w] = '0;
			mvalid[s][w] = 0;
			mdirty[s][w] = 0;
		end
	end
	repeat (16) @(posedge clk);
	reset <= 1'b0;

	repeat (20)
	begin
		@(negedge clk);
		if (mem_resp || pmem_read || pmem_write)
			stop_on_error("strobe high after reset with no request");
	end

	access("read miss", 16'h3a46, 1'b0, '0, '0);
	access("read hit", 16'h3a48, 1'b0, '0, '0);
	access("masked write", 16'h3a40, 1'b1, 16'hf00f, {4{32'hdead_beef}});
	access("read after write", 16'h3a4e, 1'b0, '0, '0);

	// five or more tags in set 5 force replacements.
	access("evict read 10", 16'h1050, 1'b0, '0, '0);
	access("evict write 11", 16'h1150, 1'b1, 16'h00ff, {4{32'h1234_5678}});
	access("evict write 12", 16'h1252, 1'b1, 16'hffff, {4{32'h0bad_cafe}});
	access("evict read 13", 16'h1354, 1'b0, '0, '0);
	for (int i = 4; i < 8; i++)
		access("evict read", {8'h10 + 8'(i), 8'h50}, 1'b0, '0, '0);
	access("reread 11", 16'h1150, 1'b0, '0, '0);
	access("reread 12", 16'h1252, 1'b0, '0, '0);

	for (int i = 0; i < 300; i++)
	begin
		r = $random(seed);
		addr = {8'h20 + 8'(r % 6), sets[(r >> 8) % 3], r[14:12], 1'b0};
		access("random mix", addr, r[20], 16'($random(seed)),
			{$random(seed), $random(seed), $random(seed), $random(seed)});
	end

	$display("*** TEST PASSED ***");
	$finish;
end

endmodule : l2_cache_tb

// ==== vlog.f ====
common/lc3b_types.sv
design/l2_array.sv
l2_cache/l2_cache_datapath.sv
l2_cache/l2_cache_control.sv
l2_cache/l2_cache.sv
verification/l2_mem_model.sv
verification/l2_cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the L2 cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module l2_cache_tb -o l2_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/l2_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	echo "simulation reported failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

exit 0
